// ==== build.f ====
+incdir+source
source/alu_pkg.sv
source/pipe_pkg.sv
source/alu.sv
source/execute_stage.sv
source/memory_stage.sv
source/exec_mem_top.sv
test/tb_exec_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then judge the run from its log.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_exec_mem \
   -f build.f -o sim_exec_mem > build.log 2>&1 \
   || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_exec_mem > sim.log 2>&1
cat sim.log

grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu
   import alu_pkg::*, pipe_pkg::*;
   (
   input  alu_ctrl_t i_alu_ctrl,
   input  word_t     i_operand_a,
   input  word_t     i_operand_b,
   output word_t     o_result
   );

   // Shift distance comes from the low bits of the first operand.
   localparam int SHAMT_WIDTH = $clog2($bits(word_t));

   // Link address step, one instruction past the jump.
   localparam word_t LINK_OFFSET = word_t'(4);

   // Upper immediate sits in the top half of the word.
   localparam int LUI_SHIFT = 16;

   logic [SHAMT_WIDTH-1:0] shamt;

   assign shamt = i_operand_a[SHAMT_WIDTH-1:0];

   //////////////////////////////
   // Operation select.
   //////////////////////////////

   always_comb begin
      case (i_alu_ctrl)
         ALU_ADD: begin
            o_result = i_operand_a + i_operand_b;
         end
         ALU_SUB: begin
            o_result = i_operand_a - i_operand_b;
         end
         ALU_AND: begin
            o_result = i_operand_a & i_operand_b;
         end
         ALU_OR: begin
            o_result = i_operand_a | i_operand_b;
         end
         ALU_XOR: begin
            o_result = i_operand_a ^ i_operand_b;
         end
         ALU_NOR: begin
            o_result = ~(i_operand_a | i_operand_b);
         end
         // Compares return 1 or 0.
         ALU_SLT: begin
            o_result = word_t'($signed(i_operand_a) < $signed(i_operand_b));
         end
         ALU_SLTU: begin
            o_result = word_t'(i_operand_a < i_operand_b);
         end
         // The second operand is the value shifted.
         ALU_SLL: begin
            o_result = i_operand_b << shamt;
         end
         ALU_SRL: begin
            o_result = i_operand_b >> shamt;
         end
         ALU_SRA: begin
            o_result = $signed(i_operand_b) >>> shamt;
         end
         ALU_LUI: begin
            o_result = i_operand_b << LUI_SHIFT;
         end
         ALU_LINK: begin
            o_result = i_operand_a + LINK_OFFSET;
         end
         default: begin
            o_result = '0;
         end
      endcase
   end

endmodule

// ==== source/alu_pkg.sv ====
package alu_pkg;

   // Width of the control code driven by the ALU decoder.
   localparam int ALU_CTRL_WIDTH = 4;

   //////////////////////////////
   // ALU operation codes.
   //////////////////////////////

   // Codes 12, 13 and 15 are free and give a zero result.
   typedef enum logic [ALU_CTRL_WIDTH-1:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_AND  = 4'd2,
      ALU_OR   = 4'd3,
      ALU_XOR  = 4'd4,
      ALU_NOR  = 4'd5,
      ALU_SLT  = 4'd6,
      ALU_SLTU = 4'd7,
      ALU_SLL  = 4'd8,
      ALU_SRL  = 4'd9,
      ALU_SRA  = 4'd10,
      ALU_LUI  = 4'd11,
      // Return address for jump and link.
      ALU_LINK = 4'd14
   } alu_ctrl_t;

endpackage

// ==== source/exec_mem_top.sv ====
`timescale 1ns/1ps

module exec_mem_top
   import alu_pkg::*, pipe_pkg::*;
   (
   input  logic      i_clock,
   input  logic      i_soft_reset,
   input  logic      i_enable_pipeline,
   input  pc_t       i_adder_pc,
   input  word_t     i_data_a,
   input  word_t     i_data_b,
   input  word_t     i_sign_ext_imm,
   input  reg_idx_t  i_reg_rt,
   input  reg_idx_t  i_reg_rd,
   input  logic      i_reg_dst,
   input  logic      i_reg_write,
   input  logic      i_alu_src,
   input  logic      i_mem_read,
   input  logic      i_mem_write,
   input  logic      i_mem_to_reg,
   input  alu_ctrl_t i_alu_ctrl,
   output logic      o_wb_reg_write,
   output word_t     o_wb_data,
   output reg_idx_t  o_wb_reg
   );

   // EX/MEM stage outputs.
   logic     ex_reg_write;
   logic     ex_mem_read;
   logic     ex_mem_write;
   logic     ex_mem_to_reg;
   word_t    ex_result;
   word_t    ex_store_data;
   reg_idx_t ex_dest_reg;

   execute_stage u_execute_stage (
      .i_clock           (i_clock),
      .i_soft_reset      (i_soft_reset),
      .i_enable_pipeline (i_enable_pipeline),
      .i_adder_pc        (i_adder_pc),
      .i_data_a          (i_data_a),
      .i_data_b          (i_data_b),
      .i_sign_ext_imm    (i_sign_ext_imm),
      .i_reg_rt          (i_reg_rt),
      .i_reg_rd          (i_reg_rd),
      .i_reg_dst         (i_reg_dst),
      .i_reg_write       (i_reg_write),
      .i_alu_src         (i_alu_src),
      .i_mem_read        (i_mem_read),
      .i_mem_write       (i_mem_write),
      .i_mem_to_reg      (i_mem_to_reg),
      .i_alu_ctrl        (i_alu_ctrl),
      .o_reg_write       (ex_reg_write),
      .o_mem_read        (ex_mem_read),
      .o_mem_write       (ex_mem_write),
      .o_mem_to_reg      (ex_mem_to_reg),
      .o_result          (ex_result),
      .o_store_data      (ex_store_data),
      .o_dest_reg        (ex_dest_reg)
   );

   memory_stage u_memory_stage (
      .i_clock           (i_clock),
      .i_soft_reset      (i_soft_reset),
      .i_enable_pipeline (i_enable_pipeline),
      .i_reg_write       (ex_reg_write),
      .i_mem_read        (ex_mem_read),
      .i_mem_write       (ex_mem_write),
      .i_mem_to_reg      (ex_mem_to_reg),
      .i_result          (ex_result),
      .i_store_data      (ex_store_data),
      .i_dest_reg        (ex_dest_reg),
      .o_wb_reg_write    (o_wb_reg_write),
      .o_wb_data         (o_wb_data),
      .o_wb_reg          (o_wb_reg)
   );

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
   import alu_pkg::*, pipe_pkg::*;
   (
   input  logic      i_clock,
   input  logic      i_soft_reset,
   input  logic      i_enable_pipeline,
   input  pc_t       i_adder_pc,
   input  word_t     i_data_a,
   input  word_t     i_data_b,
   input  word_t     i_sign_ext_imm,
   input  reg_idx_t  i_reg_rt,
   input  reg_idx_t  i_reg_rd,
   input  logic      i_reg_dst,
   input  logic      i_reg_write,
   input  logic      i_alu_src,
   input  logic      i_mem_read,
   input  logic      i_mem_write,
   input  logic      i_mem_to_reg,
   input  alu_ctrl_t i_alu_ctrl,
   output logic      o_reg_write,
   output logic      o_mem_read,
   output logic      o_mem_write,
   output logic      o_mem_to_reg,
   output word_t     o_result,
   output word_t     o_store_data,
   output reg_idx_t  o_dest_reg
   );

   word_t    operand_a;
   word_t    operand_b;
   word_t    alu_result;
   reg_idx_t dest_reg;

   //////////////////////////////
   // Operand and destination select.
   //////////////////////////////

   // Jump and link takes the PC in place of rs, zero extended.
   assign operand_a = (i_alu_ctrl == ALU_LINK) ? word_t'(i_adder_pc) : i_data_a;

   // Immediate forms replace rt with the sign extended constant.
   assign operand_b = i_alu_src ? i_sign_ext_imm : i_data_b;

   // R-type writes rd, I-type writes rt.
   assign dest_reg = i_reg_dst ? i_reg_rd : i_reg_rt;

   alu u_alu (
      .i_alu_ctrl  (i_alu_ctrl),
      .i_operand_a (operand_a),
      .i_operand_b (operand_b),
      .o_result    (alu_result)
   );

   //////////////////////////////
   // EX/MEM register.
   //////////////////////////////

   // Captured on the falling edge, held while the pipeline is stalled.
   always_ff @(negedge i_clock) begin
      if (!i_soft_reset) begin
         o_reg_write  <= 1'b0;
         o_mem_read   <= 1'b0;
         o_mem_write  <= 1'b0;
         o_mem_to_reg <= 1'b0;
         o_result     <= '0;
         o_store_data <= '0;
         o_dest_reg   <= '0;
      end else if (i_enable_pipeline) begin
         o_reg_write  <= i_reg_write;
         o_mem_read   <= i_mem_read;
         o_mem_write  <= i_mem_write;
         o_mem_to_reg <= i_mem_to_reg;
         o_result     <= alu_result;
         // Stores always take rt, never the immediate.
         o_store_data <= i_data_b;
         o_dest_reg   <= dest_reg;
      end
   end

endmodule

// ==== source/memory_stage.sv ====
`timescale 1ns/1ps

`include "mips_config.svh"

module memory_stage
   import pipe_pkg::*;
   (
   input  logic     i_clock,
   input  logic     i_soft_reset,
   input  logic     i_enable_pipeline,
   input  logic     i_reg_write,
   input  logic     i_mem_read,
   input  logic     i_mem_write,
   input  logic     i_mem_to_reg,
   input  word_t    i_result,
   input  word_t    i_store_data,
   input  reg_idx_t i_dest_reg,
   output logic     o_wb_reg_write,
   output word_t    o_wb_data,
   output reg_idx_t o_wb_reg
   );

   // Word index width for the data memory.
   localparam int DMEM_ADDR_WIDTH = $clog2(`MIPS_DMEM_DEPTH);

   // Byte address bits below the word index.
   localparam int BYTE_OFFSET = 2;

   word_t                      dmem [`MIPS_DMEM_DEPTH];
   logic [DMEM_ADDR_WIDTH-1:0] mem_addr;
   word_t                      mem_rdata;
   word_t                      wb_data;

   //////////////////////////////
   // Data memory.
   //////////////////////////////

   // Word address from the ALU result, byte offset dropped.
   assign mem_addr = i_result[DMEM_ADDR_WIDTH+BYTE_OFFSET-1:BYTE_OFFSET];

   // Contents start cleared; reset leaves them alone.
   initial begin
      for (int i = 0; i < `MIPS_DMEM_DEPTH; i++) begin
         dmem[i] = '0;
      end
   end

   // Write on the same edge that moves the store into MEM/WB.
   always @(negedge i_clock) begin
      if (i_mem_write && i_enable_pipeline) begin
         dmem[mem_addr] <= i_store_data;
      end
   end

   // Asynchronous read. Only a load puts data on this path.
   assign mem_rdata = i_mem_read ? dmem[mem_addr] : '0;

   // Loads write back memory data, everything else the ALU result.
   assign wb_data = i_mem_to_reg ? mem_rdata : i_result;

   //////////////////////////////
   // MEM/WB register.
   //////////////////////////////

   always_ff @(negedge i_clock) begin
      if (!i_soft_reset) begin
         o_wb_reg_write <= 1'b0;
         o_wb_data      <= '0;
         o_wb_reg       <= '0;
      end else if (i_enable_pipeline) begin
         o_wb_reg_write <= i_reg_write;
         o_wb_data      <= wb_data;
         o_wb_reg       <= i_dest_reg;
      end
   end

endmodule

// ==== source/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

//////////////////////////////
// Datapath sizes.
//////////////////////////////

// Register and data word width.
`define MIPS_DATA_WIDTH 32

// Architectural registers, five index bits.
`define MIPS_NUM_REGS 32

// Incremented PC as delivered by the fetch stage.
`define MIPS_PC_WIDTH 11

// Data memory size in words.
`define MIPS_DMEM_DEPTH 64

`endif

// ==== source/pipe_pkg.sv ====
package pipe_pkg;

`include "mips_config.svh"

   //////////////////////////////
   // Pipeline payload types.
   //////////////////////////////

   // One register or memory word.
   typedef logic [`MIPS_DATA_WIDTH-1:0] word_t;

   // Register file index.
   typedef logic [$clog2(`MIPS_NUM_REGS)-1:0] reg_idx_t;

   // PC + 4 coming down from fetch.
   typedef logic [`MIPS_PC_WIDTH-1:0] pc_t;

endpackage

// ==== test/tb_exec_mem.sv ====
`timescale 1ns/1ps

`include "mips_config.svh"

module tb_exec_mem
   import alu_pkg::*, pipe_pkg::*;
   ();

   localparam int NUM_OPS       = 2000;
   localparam int RESET_CYCLES  = 10;
   localparam int RESET_TIMEOUT = 50;
   localparam int RESET_AT_OP   = 1000;
   localparam int CYCLE_LIMIT   = 20000;
   localparam int ADDR_WIDTH    = $clog2(`MIPS_DMEM_DEPTH);
   localparam logic [31:0] LFSR_TAPS = 32'hD000_0001;

   logic      clock;
   logic      soft_reset;
   logic      enable_pipeline;
   pc_t       adder_pc;
   word_t     data_a;
   word_t     data_b;
   word_t     sign_ext_imm;
   reg_idx_t  reg_rt;
   reg_idx_t  reg_rd;
   logic      reg_dst;
   logic      reg_write;
   logic      alu_src;
   logic      mem_read;
   logic      mem_write;
   logic      mem_to_reg;
   alu_ctrl_t alu_ctrl;
   logic      wb_reg_write;
   word_t     wb_data;
   reg_idx_t  wb_reg;

   // Reference EX/MEM and MEM/WB contents.
   logic      m_ex_reg_write;
   logic      m_ex_mem_read;
   logic      m_ex_mem_write;
   logic      m_ex_mem_to_reg;
   word_t     m_ex_result;
   word_t     m_ex_store_data;
   reg_idx_t  m_ex_dest_reg;
   logic      m_wb_reg_write;
   word_t     m_wb_data;
   reg_idx_t  m_wb_reg;
   word_t     model_mem [`MIPS_DMEM_DEPTH];

   logic [31:0] lfsr_state;

   exec_mem_top dut0 (
      .i_clock           (clock),
      .i_soft_reset      (soft_reset),
      .i_enable_pipeline (enable_pipeline),
      .i_adder_pc        (adder_pc),
      .i_data_a          (data_a),
      .i_data_b          (data_b),
      .i_sign_ext_imm    (sign_ext_imm),
      .i_reg_rt          (reg_rt),
      .i_reg_rd          (reg_rd),
      .i_reg_dst         (reg_dst),
      .i_reg_write       (reg_write),
      .i_alu_src         (alu_src),
      .i_mem_read        (mem_read),
      .i_mem_write       (mem_write),
      .i_mem_to_reg      (mem_to_reg),
      .i_alu_ctrl        (alu_ctrl),
      .o_wb_reg_write    (wb_reg_write),
      .o_wb_data         (wb_data),
      .o_wb_reg          (wb_reg)
   );

   initial begin
      clock = 1'b0;
      forever begin
         #5 clock = ~clock;
      end
   end

   //////////////////////////////
   // Random source.
   //////////////////////////////

   function automatic logic lfsr_bit();
      logic out_bit;
      out_bit = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) begin
         lfsr_state = lfsr_state ^ LFSR_TAPS;
      end
      return out_bit;
   endfunction

   function automatic logic [31:0] rand_bits(input int count);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < count; i++) begin
         value = {value[30:0], lfsr_bit()};
      end
      return value;
   endfunction

   //////////////////////////////
   // Reference model.
   //////////////////////////////

   function automatic word_t model_alu(input alu_ctrl_t ctrl, input word_t a, input word_t b);
      logic [63:0] wide;
      case (ctrl)
         ALU_ADD:  return a + b;
         ALU_SUB:  return a - b;
         ALU_AND:  return a & b;
         ALU_OR:   return a | b;
         ALU_XOR:  return a ^ b;
         ALU_NOR:  return ~(a | b);
         ALU_SLT: begin
            // Differing signs decide on the sign bit alone.
            if (a[31] != b[31]) begin
               return {31'd0, a[31]};
            end
            return {31'd0, a < b};
         end
         ALU_SLTU: return {31'd0, a < b};
         ALU_SLL:  return b << a[4:0];
         ALU_SRL:  return b >> a[4:0];
         ALU_SRA: begin
            wide = {{32{b[31]}}, b} >> a[4:0];
            return wide[31:0];
         end
         ALU_LUI:  return {b[15:0], 16'h0000};
         ALU_LINK: return a + 32'd4;
         default:  return '0;
      endcase
   endfunction

   task automatic clear_model_pipe();
      m_ex_reg_write  = 1'b0;
      m_ex_mem_read   = 1'b0;
      m_ex_mem_write  = 1'b0;
      m_ex_mem_to_reg = 1'b0;
      m_ex_result     = '0;
      m_ex_store_data = '0;
      m_ex_dest_reg   = '0;
      m_wb_reg_write  = 1'b0;
      m_wb_data       = '0;
      m_wb_reg        = '0;
   endtask

   // One falling edge of the pipeline, taken from the driven inputs.
   task automatic advance_model();
      logic [ADDR_WIDTH-1:0] addr;
      logic                  write_now;
      word_t                 load_word;
      word_t                 store_word;
      word_t                 op_a;
      word_t                 op_b;
      addr = m_ex_result[ADDR_WIDTH+1:2];
      write_now = m_ex_mem_write && enable_pipeline;
      store_word = m_ex_store_data;
      load_word = m_ex_mem_read ? model_mem[addr] : '0;
      if (!soft_reset) begin
         clear_model_pipe();
      end else if (enable_pipeline) begin
         m_wb_reg_write  = m_ex_reg_write;
         m_wb_data       = m_ex_mem_to_reg ? load_word : m_ex_result;
         m_wb_reg        = m_ex_dest_reg;
         op_a = (alu_ctrl == ALU_LINK) ? {21'd0, adder_pc} : data_a;
         op_b = alu_src ? sign_ext_imm : data_b;
         m_ex_result     = model_alu(alu_ctrl, op_a, op_b);
         m_ex_store_data = data_b;
         m_ex_dest_reg   = reg_dst ? reg_rd : reg_rt;
         m_ex_reg_write  = reg_write;
         m_ex_mem_read   = mem_read;
         m_ex_mem_write  = mem_write;
         m_ex_mem_to_reg = mem_to_reg;
      end
      // Memory is untouched by reset.
      if (write_now) begin
         model_mem[addr] = store_word;
      end
   endtask

   //////////////////////////////
   // Stimulus and checks.
   //////////////////////////////

   task automatic gen_op();
      logic [2:0]  kind;
      logic [15:0] imm16;
      kind         = 3'(rand_bits(3));
      imm16        = 16'(rand_bits(16));
      adder_pc     = pc_t'(rand_bits(`MIPS_PC_WIDTH));
      data_a       = rand_bits(32);
      data_b       = rand_bits(32);
      sign_ext_imm = {{16{imm16[15]}}, imm16};
      reg_rt       = reg_idx_t'(rand_bits(5));
      reg_rd       = reg_idx_t'(rand_bits(5));
      reg_dst      = 1'(rand_bits(1));
      reg_write    = 1'(rand_bits(1));
      alu_src      = 1'(rand_bits(1));
      mem_read     = 1'(rand_bits(1));
      mem_write    = 1'b0;
      mem_to_reg   = 1'b0;
      alu_ctrl     = alu_ctrl_t'(4'(rand_bits(4)));
      case (kind)
         3'd4: alu_ctrl = ALU_LINK;
         3'd5, 3'd6: begin
            // Stores go to words 0 to 15.
            alu_ctrl     = ALU_ADD;
            alu_src      = 1'b1;
            sign_ext_imm = '0;
            data_a       = {24'(rand_bits(24)), 2'b00, 4'(rand_bits(4)), 2'b00};
            mem_read     = 1'b0;
            mem_write    = 1'b1;
            reg_write    = 1'b0;
         end
         3'd7: begin
            // Loads reach words 0 to 31. The upper half is never stored.
            alu_ctrl     = ALU_ADD;
            alu_src      = 1'b1;
            sign_ext_imm = '0;
            data_a       = {24'(rand_bits(24)), 1'b0, 5'(rand_bits(5)), 2'b00};
            mem_read     = 1'b1;
            mem_to_reg   = 1'b1;
            reg_write    = 1'b1;
         end
         default: begin
         end
      endcase
   endtask

   task automatic abort_run(input string reason);
      $display("Regression failed");
      $fatal(1, "%s", reason);
   endtask

   task automatic expect_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      assert (got === exp) else begin
         $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
         abort_run("output mismatch");
      end
   endtask

   task automatic finish_cycle();
      @(negedge clock);
      advance_model();
      #1;
      expect_value("o_wb_reg_write", 32'(wb_reg_write), 32'(m_wb_reg_write));
      expect_value("o_wb_reg", 32'(wb_reg), 32'(m_wb_reg));
      expect_value("o_wb_data", wb_data, m_wb_data);
   endtask

   initial begin
      int cycles;
      int ops_done;
      int stall_left;
      int reset_left;
      int waited;
      bit reset_done;
      cycles          = 0;
      ops_done        = 0;
      reset_left      = 0;
      waited          = 0;
      reset_done      = 1'b0;
      lfsr_state      = 32'd75;
      soft_reset      = 1'b0;
      enable_pipeline = 1'b0;
      gen_op();
      clear_model_pipe();
      for (int i = 0; i < `MIPS_DMEM_DEPTH; i++) begin
         model_mem[i] = '0;
      end

      // Reset with the pipeline stalled, released after the reset cycles.
      while (soft_reset !== 1'b1) begin
         if (waited >= RESET_TIMEOUT) begin
            abort_run("timed out waiting for reset release");
         end
         @(posedge clock);
         #1;
         gen_op();
         soft_reset = (waited >= RESET_CYCLES);
         finish_cycle();
         waited++;
      end

      stall_left = 4;
      while (ops_done < NUM_OPS) begin
         if (cycles >= CYCLE_LIMIT) begin
            abort_run("timed out before all operations were issued");
         end
         @(posedge clock);
         #1;
         gen_op();
         if (ops_done == RESET_AT_OP && !reset_done) begin
            reset_left = 3;
            reset_done = 1'b1;
         end
         soft_reset = (reset_left == 0);
         if (reset_left > 0) begin
            reset_left--;
         end
         if (stall_left > 0) begin
            enable_pipeline = 1'b0;
            stall_left--;
         end else begin
            enable_pipeline = 1'b1;
            if (rand_bits(4) == 0) begin
               stall_left = int'(rand_bits(3)) + 1;
            end
         end
         if (enable_pipeline && soft_reset) begin
            ops_done++;
         end
         finish_cycle();
         cycles++;
      end

      // Drain the last two operations.
      repeat (2) begin
         @(posedge clock);
         #1;
         gen_op();
         enable_pipeline = 1'b1;
         finish_cycle();
      end

      $display("Regression passed");
      $finish;
   end

endmodule
